// File: logic/game_pkg.sv
`default_nettype none

package game_pkg;

   // colors, also the lamp and key index
   localparam int color_w    = 2;
   localparam int num_colors = 4;
   localparam logic [color_w-1:0] color_red    = 2'd0;
   localparam logic [color_w-1:0] color_green  = 2'd1;
   localparam logic [color_w-1:0] color_yellow = 2'd2;
   localparam logic [color_w-1:0] color_blue   = 2'd3;

   // sequence memory, one entry per round
   localparam int addr_w    = 5;
   localparam int seq_depth = 32;

   // step timing in clock cycles
   localparam int timer_w   = 6;
   localparam int count_seq = 33;
   localparam int dec_seq   = 1;
   localparam int count_key = 33;

   // speaker half-period is threshold + 2
   localparam int tone_error  = 1;
   localparam int tone_red    = 2;
   localparam int tone_green  = 3;
   localparam int tone_yellow = 4;
   localparam int tone_blue   = 5;
   localparam int tone_win    = 6;
   localparam int tone_cnt_w  = 3;

   localparam int code_w = color_w + 1;
   localparam logic [code_w-1:0] code_win  = 3'd4;
   localparam logic [code_w-1:0] code_loss = 3'd5;

   // color view for lamp tones, code view for win and loss
   typedef union packed {
      struct packed {
         logic               pad;
         logic [color_w-1:0] color;
      } col;
      logic [code_w-1:0] code;
   } tone_code_t;

   // controller states
   localparam int state_w = 5;
   localparam logic [state_w-1:0] st_idle      = 5'd0;
   localparam logic [state_w-1:0] st_append    = 5'd1;
   localparam logic [state_w-1:0] st_show_addr = 5'd2;
   localparam logic [state_w-1:0] st_show_wait = 5'd3;
   localparam logic [state_w-1:0] st_show_on   = 5'd4;
   localparam logic [state_w-1:0] st_show_hold = 5'd5;
   localparam logic [state_w-1:0] st_show_gap  = 5'd6;
   localparam logic [state_w-1:0] st_key_addr  = 5'd7;
   localparam logic [state_w-1:0] st_key_wait  = 5'd8;
   localparam logic [state_w-1:0] st_key_poll  = 5'd9;
   localparam logic [state_w-1:0] st_key_lamp  = 5'd10;
   localparam logic [state_w-1:0] st_key_hold  = 5'd11;
   localparam logic [state_w-1:0] st_key_gap   = 5'd12;
   localparam logic [state_w-1:0] st_err_lamp  = 5'd13;
   localparam logic [state_w-1:0] st_err_hold  = 5'd14;
   localparam logic [state_w-1:0] st_win       = 5'd15;
   localparam logic [state_w-1:0] st_loss      = 5'd16;

endpackage

`default_nettype wire

// File: logic/sequence_store.sv
`timescale 1ns/1ps
`default_nettype none

module sequence_store (
   input  logic                         clock,
   input  logic                         reset,
   input  logic                         wr,
   input  logic [game_pkg::addr_w-1:0]  addr,
   output logic [game_pkg::color_w-1:0] color_now,
   output logic [game_pkg::color_w-1:0] read_color
);
   import game_pkg::*;

   logic [color_w-1:0] mem [seq_depth];

   // free-running color source, wraps through all four colors
   always_ff @(posedge clock)
   begin
      if (reset)
         color_now <= '0;
      else
         color_now <= color_now + 1'b1;
   end

   // read data lags the address by one cycle
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         read_color <= '0;
         for (int i = 0; i < seq_depth; i++)
            mem[i] <= '0;
      end
      else
      begin
         read_color <= mem[addr];
         if (wr)
            mem[addr] <= color_now;
      end
   end

   // controller must always present a defined address
   addr_known: assert property (@(posedge clock) disable iff (reset)
      !$isunknown(addr));

endmodule

`default_nettype wire

// File: logic/tone_generator.sv
`timescale 1ns/1ps
`default_nettype none

module tone_generator (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 play,
   input  game_pkg::tone_code_t tone,
   output logic                 speaker
);
   import game_pkg::*;

   logic [tone_cnt_w-1:0] count;
   logic [tone_cnt_w-1:0] threshold;
   logic                  known;
   logic                  level;

   // event code to half-period threshold
   always_comb
   begin
      known     = 1'b1;
      threshold = '0;
      case (tone.code)
         {1'b0, color_red}:    threshold = tone_cnt_w'(tone_red);
         {1'b0, color_green}:  threshold = tone_cnt_w'(tone_green);
         {1'b0, color_yellow}: threshold = tone_cnt_w'(tone_yellow);
         {1'b0, color_blue}:   threshold = tone_cnt_w'(tone_blue);
         code_win:             threshold = tone_cnt_w'(tone_win);
         code_loss:            threshold = tone_cnt_w'(tone_error);
         default:              known = 1'b0;
      endcase
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         count <= '0;
         level <= 1'b0;
      end
      else if (!play)
      begin
         count <= '0;
         level <= 1'b0;
      end
      else if (!known)
         count <= '0;
      else if (count > threshold)
      begin
         // count ran 0..threshold+1, so threshold+2 cycles per half wave
         count <= '0;
         level <= ~level;
      end
      else
         count <= count + 1'b1;
   end

   assign speaker = level;

   // silence follows play falling within one cycle
   quiet_when_off: assert property (@(posedge clock) disable iff (reset)
      !$past(play) |-> !speaker);

endmodule

`default_nettype wire

// File: logic/game_control.sv
`timescale 1ns/1ps
`default_nettype none

module game_control (
   input  logic                            clock,
   input  logic                            reset,
   input  logic                            start,
   input  logic [game_pkg::num_colors-1:0] key,
   input  logic [game_pkg::color_w-1:0]    read_color,
   output logic                            wr,
   output logic [game_pkg::addr_w-1:0]     addr,
   output logic                            play,
   output game_pkg::tone_code_t            tone,
   output logic [game_pkg::num_colors-1:0] lamp,
   output logic                            nloss
);
   import game_pkg::*;

   logic [state_w-1:0] state;
   logic [timer_w-1:0] timer;
   logic [timer_w-1:0] show_time;
   logic [addr_w-1:0]  len;
   logic [addr_w-1:0]  scan;
   logic [color_w-1:0] ind;
   logic               key_hit;
   logic [color_w-1:0] key_color;

   function automatic logic [num_colors-1:0] lamp_of(input logic [color_w-1:0] c);
      lamp_of    = '0;
      lamp_of[c] = 1'b1;
   endfunction

   // lowest-numbered pressed key wins
   always_comb
   begin
      key_hit   = 1'b0;
      key_color = '0;
      for (int i = num_colors - 1; i >= 0; i--)
      begin
         if (key[i])
         begin
            key_hit   = 1'b1;
            key_color = color_w'(i);
         end
      end
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state     <= st_idle;
         timer     <= '0;
         show_time <= '0;
         len       <= '0;
         scan      <= '0;
         ind       <= '0;
         wr        <= 1'b0;
         addr      <= '0;
         play      <= 1'b0;
         tone      <= '0;
         lamp      <= '0;
         nloss     <= 1'b0;
      end
      else if (start)
      begin
         // clear phase, held while start stays high
         lamp      <= '0;
         nloss     <= 1'b0;
         play      <= 1'b0;
         wr        <= 1'b0;
         len       <= '0;
         show_time <= timer_w'(count_seq);
         state     <= st_append;
      end
      else
      begin
         case (state)
            st_append:
            begin
               // store takes color_now at the length pointer
               scan  <= '0;
               wr    <= 1'b1;
               addr  <= len;
               state <= st_show_addr;
            end
            st_show_addr:
            begin
               wr    <= 1'b0;
               addr  <= scan;
               state <= st_show_wait;
            end
            st_show_wait:
               state <= st_show_on;
            st_show_on:
            begin
               lamp           <= lamp_of(read_color);
               play           <= 1'b1;
               tone.col.pad   <= 1'b0;
               tone.col.color <= read_color;
               timer          <= show_time;
               state          <= st_show_hold;
            end
            st_show_hold:
            begin
               if (timer == '0)
               begin
                  lamp  <= '0;
                  play  <= 1'b0;
                  timer <= show_time;
                  state <= st_show_gap;
               end
               else
                  timer <= timer - 1'b1;
            end
            st_show_gap:
            begin
               if (timer != '0)
                  timer <= timer - 1'b1;
               else if (scan != len)
               begin
                  scan  <= scan + 1'b1;
                  state <= st_show_addr;
               end
               else
               begin
                  scan  <= '0;
                  state <= st_key_addr;
               end
            end
            st_key_addr:
            begin
               timer <= timer_w'(count_key);
               addr  <= scan;
               state <= st_key_wait;
            end
            st_key_wait:
               state <= st_key_poll;
            st_key_poll:
            begin
               if (timer == '0)
               begin
                  // timeout, the expected color stays lit
                  nloss     <= 1'b1;
                  lamp      <= lamp_of(read_color);
                  play      <= 1'b1;
                  tone.code <= code_loss;
                  state     <= st_loss;
               end
               else if (key_hit)
               begin
                  ind            <= key_color;
                  play           <= 1'b1;
                  tone.col.pad   <= 1'b0;
                  tone.col.color <= key_color;
                  timer          <= show_time;
                  if (key_color == read_color)
                     state <= st_key_lamp;
                  else
                  begin
                     nloss <= 1'b1;
                     state <= st_err_lamp;
                  end
               end
               else
                  timer <= timer - 1'b1;
            end
            st_key_lamp:
            begin
               lamp  <= lamp_of(ind);
               state <= st_key_hold;
            end
            st_key_hold:
            begin
               if (timer == '0)
               begin
                  lamp  <= '0;
                  play  <= 1'b0;
                  timer <= show_time;
                  state <= st_key_gap;
               end
               else
                  timer <= timer - 1'b1;
            end
            st_key_gap:
            begin
               if (timer != '0)
                  timer <= timer - 1'b1;
               else if (scan != len)
               begin
                  scan  <= scan + 1'b1;
                  state <= st_key_addr;
               end
               else if (len != addr_w'(seq_depth - 1))
               begin
                  // next round is one step longer and a bit faster
                  len       <= len + 1'b1;
                  show_time <= show_time - timer_w'(dec_seq);
                  state     <= st_append;
               end
               else
               begin
                  lamp      <= '1;
                  play      <= 1'b1;
                  tone.code <= code_win;
                  state     <= st_win;
               end
            end
            st_err_lamp:
            begin
               lamp  <= lamp_of(ind);
               state <= st_err_hold;
            end
            st_err_hold:
            begin
               // pressed color for one show time, then the expected one
               if (timer == '0)
               begin
                  lamp      <= lamp_of(read_color);
                  tone.code <= code_loss;
                  state     <= st_loss;
               end
               else
                  timer <= timer - 1'b1;
            end
            st_idle, st_win, st_loss:
               // wait here for start
               state <= state;
            default:
               state <= st_idle;
         endcase
      end
   end

   lamp_single: assert property (@(posedge clock) disable iff (reset)
      (state != st_win) |-> $onehot0(lamp));

   nloss_held: assert property (@(posedge clock) disable iff (reset)
      $fell(nloss) |-> $past(start));

endmodule

`default_nettype wire

// File: logic/simon_game.sv
`timescale 1ns/1ps
`default_nettype none

module simon_game (
   input  logic                            clock,
   input  logic                            reset,
   input  logic                            start,
   input  logic [game_pkg::num_colors-1:0] key,
   output logic [game_pkg::num_colors-1:0] lamp,
   output logic                            nloss,
   output logic                            speaker
);
   import game_pkg::*;

   logic               wr;
   logic [addr_w-1:0]  addr;
   logic [color_w-1:0] read_color;
   logic               play;
   tone_code_t         tone;

   // the store writes its own color source, so color_now stays internal
   sequence_store u_store (
      .clock      (clock),
      .reset      (reset),
      .wr         (wr),
      .addr       (addr),
      .color_now  (),
      .read_color (read_color)
   );

   game_control u_control (
      .clock      (clock),
      .reset      (reset),
      .start      (start),
      .key        (key),
      .read_color (read_color),
      .wr         (wr),
      .addr       (addr),
      .play       (play),
      .tone       (tone),
      .lamp       (lamp),
      .nloss      (nloss)
   );

   tone_generator u_tone (
      .clock   (clock),
      .reset   (reset),
      .play    (play),
      .tone    (tone),
      .speaker (speaker)
   );

endmodule

`default_nettype wire

// File: tests/simon_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module simon_game_tb;
   import game_pkg::*;

   localparam int games        = 4;
   localparam int cycle_limit  = games * seq_depth * seq_depth * 4 * count_seq;
   localparam int hold_cycles  = 20;
   localparam int mode_correct = 0;
   localparam int mode_wrong   = 1;
   localparam int mode_silent  = 2;

   logic                  clock;
   logic                  reset;
   logic                  start;
   logic [num_colors-1:0] key;
   logic [num_colors-1:0] lamp;
   logic                  nloss;
   logic                  speaker;

   logic [31:0]        rng_state;
   int                 error_count;
   logic [color_w-1:0] cur_seq  [seq_depth];
   logic [color_w-1:0] prev_seq [seq_depth];

   simon_game UUT (
      .clock   (clock),
      .reset   (reset),
      .start   (start),
      .key     (key),
      .lamp    (lamp),
      .nloss   (nloss),
      .speaker (speaker)
   );

   always #5 clock = ~clock;

   task automatic compare_value(input int got, input int expected, input string what);
      if (got != expected)
      begin
         error_count++;
         $display("error at %0t ns: %s, got %0d, expected %0d", $time, what, got, expected);
         $display("Something failed");
         $fatal(1);
      end
   endtask

   function automatic int unsigned next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return int'(rng_state[31:16]);
   endfunction

   function automatic logic [num_colors-1:0] onehot_of(input logic [color_w-1:0] c);
      return num_colors'(1) << c;
   endfunction

   // lowest lit lamp gives the color
   function automatic logic [color_w-1:0] color_of(input logic [num_colors-1:0] l);
      color_of = '0;
      for (int i = num_colors - 1; i >= 0; i--)
      begin
         if (l[i])
            color_of = color_w'(i);
      end
   endfunction

   function automatic int half_period_of(input logic [color_w-1:0] c);
      case (c)
         color_red:    return tone_red + 2;
         color_green:  return tone_green + 2;
         color_yellow: return tone_yellow + 2;
         default:      return tone_blue + 2;
      endcase
   endfunction

   task automatic wait_lamp();
      while (lamp == '0)
         @(negedge clock);
   endtask

   // track one lit pattern, checking every full half-period of the speaker
   task automatic watch_pulse(input logic [num_colors-1:0] pattern, input int half,
                              input string what);
      logic last;
      int   run;
      int   seen;
      last = speaker;
      run  = 0;
      seen = 0;
      while (lamp == pattern)
      begin
         @(negedge clock);
         run++;
         if (lamp == pattern && speaker != last)
         begin
            if (seen > 0)
               compare_value(run, half, what);
            seen++;
            run  = 0;
            last = speaker;
         end
      end
   endtask

   // first toggle may come early, so only later intervals count
   task automatic measure_tone(input int half, input int periods, input string what);
      logic last;
      int   run;
      int   seen;
      last = speaker;
      run  = 0;
      seen = 0;
      while (seen <= periods)
      begin
         @(negedge clock);
         run++;
         if (speaker != last)
         begin
            if (seen > 0)
               compare_value(run, half, what);
            seen++;
            run  = 0;
            last = speaker;
         end
      end
   endtask

   task automatic show_round(input int n);
      logic [num_colors-1:0] pattern;
      for (int i = 0; i < n; i++)
      begin
         wait_lamp();
         pattern = lamp;
         compare_value($countones(pattern), 1, "show pulse lights one lamp");
         compare_value(int'(nloss), 0, "nloss low during show");
         cur_seq[i] = color_of(pattern);
         watch_pulse(pattern, half_period_of(cur_seq[i]), "show tone half-period");
      end
      // new round repeats the old one plus one step
      for (int i = 0; i < n - 1; i++)
         compare_value(int'(cur_seq[i]), int'(prev_seq[i]), "sequence prefix kept");
   endtask

   task automatic press_step(input logic [color_w-1:0] expected, input int mode);
      logic [color_w-1:0]    pressed;
      logic [num_colors-1:0] pattern;
      int                    delay;
      int                    waited;
      if (mode == mode_silent)
      begin
         waited = 0;
         while (!nloss)
         begin
            @(negedge clock);
            waited++;
         end
         compare_value(int'(waited > count_key), 1, "loss only after the key window");
         compare_value(int'(lamp), int'(onehot_of(expected)), "timeout shows expected color");
      end
      else
      begin
         if (mode == mode_wrong)
            pressed = expected + color_w'(1 + next_random() % 3);
         else
            pressed = expected;
         delay = int'(next_random() % count_key);
         repeat (delay)
         begin
            @(negedge clock);
            compare_value(int'(lamp), 0, "lamps dark before the key");
         end
         @(posedge clock);
         key <= onehot_of(pressed);
         @(negedge clock);
         wait_lamp();
         pattern = lamp;
         compare_value(int'(pattern), int'(onehot_of(pressed)), "lamp shows pressed key");
         compare_value(int'(nloss), int'(mode == mode_wrong), "nloss after key");
         @(posedge clock);
         key <= '0;
         @(negedge clock);
         watch_pulse(pattern, half_period_of(pressed), "key tone half-period");
         if (mode == mode_wrong)
            compare_value(int'(lamp), int'(onehot_of(expected)), "loss shows expected color");
         else
            compare_value(int'(lamp), 0, "lamps dark after key pulse");
      end
   endtask

   task automatic hold_end(input logic [num_colors-1:0] pattern, input logic lost);
      if (lost)
         measure_tone(tone_error + 2, 3, "loss tone half-period");
      else
         measure_tone(tone_win + 2, 3, "win tone half-period");
      repeat (hold_cycles)
      begin
         @(negedge clock);
         compare_value(int'(lamp), int'(pattern), "end lamps held");
         compare_value(int'(nloss), int'(lost), "end nloss held");
      end
   endtask

   task automatic play_game(input int loss_round, input int loss_mode);
      int fail_step;
      bit lost;
      lost = 1'b0;
      @(posedge clock);
      start <= 1'b1;
      repeat (2) @(posedge clock);
      start <= 1'b0;
      @(negedge clock);
      for (int n = 1; n <= seq_depth && !lost; n++)
      begin
         show_round(n);
         fail_step = (n == loss_round) ? int'(next_random() % n) : -1;
         for (int s = 0; s < n && !lost; s++)
         begin
            if (s == fail_step)
            begin
               press_step(cur_seq[s], loss_mode);
               hold_end(onehot_of(cur_seq[s]), 1'b1);
               lost = 1'b1;
            end
            else
               press_step(cur_seq[s], mode_correct);
         end
         for (int i = 0; i < n; i++)
            prev_seq[i] = cur_seq[i];
      end
      if (!lost)
      begin
         wait_lamp();
         compare_value(int'(lamp), int'({num_colors{1'b1}}), "win lights all lamps");
         compare_value(int'(nloss), 0, "nloss low on win");
         hold_end({num_colors{1'b1}}, 1'b0);
      end
   endtask

   initial
   begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < cycle_limit)
      begin
         @(posedge clock);
         cycles++;
      end
      $display("timeout: the game never ended within %0d cycles", cycle_limit);
      $display("Something failed");
      $fatal(1);
   end

   initial
   begin
      clock       = 1'b0;
      reset       = 1'b1;
      start       = 1'b0;
      key         = '0;
      rng_state   = 32'd49;
      error_count = 0;
      repeat (2) @(posedge clock);
      reset <= 1'b0;
      // quiet until the first start
      repeat (5)
      begin
         @(negedge clock);
         compare_value(int'(lamp), 0, "lamps dark after reset");
         compare_value(int'(nloss), 0, "nloss low after reset");
         compare_value(int'(speaker), 0, "speaker low after reset");
      end
      play_game(int'(next_random() % seq_depth) + 1, mode_wrong);
      play_game(int'(next_random() % seq_depth) + 1, mode_silent);
      play_game(int'(next_random() % seq_depth) + 1,
                (next_random() % 2 == 0) ? mode_wrong : mode_silent);
      // last game never loses
      play_game(0, mode_correct);
      if (error_count == 0)
      begin
         $display("Everything OK");
         $finish;
      end
      else
      begin
         $display("Something failed");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

// File: compile.f
logic/game_pkg.sv
logic/sequence_store.sv
logic/tone_generator.sv
logic/game_control.sv
logic/simon_game.sv
tests/simon_game_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= simon_game_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) 2>&1 | tee $(LOG)

check: run
	@if grep -q "Something failed" $(LOG) || ! grep -q "Everything OK" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
